// File: design/controlPkg.sv
package controlPkg;

	//////////////////////////////////////////////////
	// Field widths
	//////////////////////////////////////////////////

	typedef logic [4:0] opcodeT;
	typedef logic [2:0] aluOpT;
	typedef logic [1:0] selT;

	// Bit order beq, bne, blt, bgt, blet, bget
	typedef logic [5:0] branchMaskT;

	//////////////////////////////////////////////////
	// Opcodes
	//////////////////////////////////////////////////

	localparam opcodeT opAdd  = 5'd0;
	localparam opcodeT opAddi = 5'd1;
	localparam opcodeT opSub  = 5'd2;
	localparam opcodeT opJump = 5'd3;
	localparam opcodeT opCall = 5'd4;
	localparam opcodeT opBeq  = 5'd5;
	localparam opcodeT opBne  = 5'd6;
	// 7 to 10 are unused and run as nop
	localparam opcodeT opOr   = 5'd11;
	localparam opcodeT opAnd  = 5'd12;
	localparam opcodeT opNot  = 5'd13;
	localparam opcodeT opNop  = 5'd14;
	localparam opcodeT opComp = 5'd15;
	localparam opcodeT opSll  = 5'd16;
	localparam opcodeT opSrl  = 5'd17;
	localparam opcodeT opBlt  = 5'd18;
	localparam opcodeT opBgt  = 5'd19;
	localparam opcodeT opBlet = 5'd20;
	localparam opcodeT opBget = 5'd21;
	localparam opcodeT opJr   = 5'd22;

	// ALU function codes
	localparam aluOpT aluAdd  = 3'd0;
	localparam aluOpT aluSub  = 3'd1;
	localparam aluOpT aluAnd  = 3'd2;
	localparam aluOpT aluOr   = 3'd3;
	localparam aluOpT aluNot  = 3'd4;
	localparam aluOpT aluSll  = 3'd5;
	localparam aluOpT aluSrl  = 3'd6;
	localparam aluOpT aluComp = 3'd7;

	//////////////////////////////////////////////////
	// Sequencing and decode
	//////////////////////////////////////////////////

	typedef enum logic [2:0] {
		idleStep,
		fetchStep,
		decodeStep,
		executeStep,
		writebackStep
	} stepT;

	typedef enum logic [2:0] {
		aluReg,
		aluImm,
		shiftImm,
		branch,
		jump,
		call,
		jumpReg,
		nop
	} instrClassT;

	// Same order as the branch mask bits
	typedef enum logic [2:0] {
		beqKind,
		bneKind,
		bltKind,
		bgtKind,
		bletKind,
		bgetKind
	} branchKindT;

endpackage

// File: design/stepSequencer.sv
module stepSequencer
	import controlPkg::*;
(
	input  logic       Reset,
	input  logic       Clock,
	input  instrClassT instrClass,
	output stepT       step
);

	stepT nextStep;

	//////////////////////////////////////////////////
	// Next step
	//////////////////////////////////////////////////

	always_comb begin
		nextStep = idleStep;
		case (step)
			idleStep: begin
				nextStep = fetchStep;
			end
			fetchStep: begin
				nextStep = decodeStep;
			end
			decodeStep: begin
				nextStep = executeStep;
			end
			executeStep: begin
				// Tail depends on what was decoded
				case (instrClass)
					aluReg, aluImm, shiftImm: begin
						nextStep = writebackStep;
					end
					branch, jump, call, jumpReg: begin
						nextStep = idleStep;
					end
					default: begin
						nextStep = fetchStep;
					end
				endcase
			end
			writebackStep: begin
				nextStep = fetchStep;
			end
			default: begin
				nextStep = idleStep;
			end
		endcase
	end

	//////////////////////////////////////////////////
	// Step register
	//////////////////////////////////////////////////

	always_ff @(posedge Reset or posedge Clock) begin
		if (Clock) begin
			step <= idleStep;
		end else begin
			step <= nextStep;
		end
	end

endmodule

// File: design/opcodeDecoder.sv
module opcodeDecoder
	import controlPkg::*;
(
	input  logic       Reset,
	input  logic       Clock,
	input  stepT       step,
	input  opcodeT     opcode,
	output instrClassT instrClass,
	output aluOpT      aluOp,
	output branchKindT branchKind
);

	instrClassT decClass;
	aluOpT      decAluOp;
	branchKindT decKind;

	//////////////////////////////////////////////////
	// Opcode classification
	//////////////////////////////////////////////////

	always_comb begin
		decClass = nop;
		decAluOp = aluAdd;
		decKind  = beqKind;
		case (opcode)
			opAdd:  begin decClass = aluReg;   decAluOp = aluAdd;  end
			opSub:  begin decClass = aluReg;   decAluOp = aluSub;  end
			opAnd:  begin decClass = aluReg;   decAluOp = aluAnd;  end
			opOr:   begin decClass = aluReg;   decAluOp = aluOr;   end
			opNot:  begin decClass = aluReg;   decAluOp = aluNot;  end
			opComp: begin decClass = aluReg;   decAluOp = aluComp; end
			opAddi: begin decClass = aluImm;   decAluOp = aluAdd;  end
			opSll:  begin decClass = shiftImm; decAluOp = aluSll;  end
			opSrl:  begin decClass = shiftImm; decAluOp = aluSrl;  end
			opBeq:  begin decClass = branch;   decAluOp = aluSub; decKind = beqKind;  end
			opBne:  begin decClass = branch;   decAluOp = aluSub; decKind = bneKind;  end
			opBlt:  begin decClass = branch;   decAluOp = aluSub; decKind = bltKind;  end
			opBgt:  begin decClass = branch;   decAluOp = aluSub; decKind = bgtKind;  end
			opBlet: begin decClass = branch;   decAluOp = aluSub; decKind = bletKind; end
			opBget: begin decClass = branch;   decAluOp = aluSub; decKind = bgetKind; end
			opJump: begin decClass = jump;    end
			opCall: begin decClass = call;    end
			opJr:   begin decClass = jumpReg; end
			// nop and anything undefined
			default: begin
				decClass = nop;
			end
		endcase
	end

	//////////////////////////////////////////////////
	// Decode latch
	//////////////////////////////////////////////////

	// Loaded only on the edge that ends decode
	always_ff @(posedge Reset or posedge Clock) begin
		if (Clock) begin
			instrClass <= nop;
			aluOp      <= aluAdd;
			branchKind <= beqKind;
		end else if (step == decodeStep) begin
			instrClass <= decClass;
			aluOp      <= decAluOp;
			branchKind <= decKind;
		end
	end

endmodule

// File: design/controlEncoder.sv
module controlEncoder
	import controlPkg::*;
(
	input  stepT       step,
	input  instrClassT instrClass,
	input  aluOpT      aluOp,
	input  branchKindT branchKind,
	output logic       pcWrite,
	output logic       memRead,
	output logic       irWrite,
	output logic       aluSrcA,
	output logic       zeSe,
	output logic       rsRt,
	output logic       writeReg,
	output logic       oldNew,
	output selT        aluSrcB,
	output selT        pcSource,
	output selT        regDest,
	output selT        regData,
	output selT        rsRd,
	output aluOpT      aluOpOut,
	output branchMaskT branchEnable
);

	always_comb begin
		pcWrite      = 1'b0;
		memRead      = 1'b0;
		irWrite      = 1'b0;
		aluSrcA      = 1'b0;
		zeSe         = 1'b0;
		rsRt         = 1'b0;
		writeReg     = 1'b0;
		oldNew       = 1'b0;
		aluSrcB      = 2'd0;
		pcSource     = 2'd0;
		regDest      = 2'd0;
		regData      = 2'd0;
		rsRd         = 2'd0;
		aluOpOut     = aluAdd;
		branchEnable = '0;

		case (step)
			fetchStep: begin
				// PC + 1 while the instruction is read
				pcWrite  = 1'b1;
				memRead  = 1'b1;
				irWrite  = 1'b1;
				aluSrcB  = 2'd1;
				pcSource = 2'd1;
			end
			decodeStep: begin
				// Branch target computed ahead of time
				aluSrcB  = 2'd2;
				pcSource = 2'd1;
				zeSe     = 1'b1;
			end
			executeStep: begin
				case (instrClass)
					aluReg: begin
						aluSrcA  = 1'b1;
						pcSource = 2'd1;
						rsRt     = 1'b1;
						aluOpOut = aluOp;
					end
					aluImm, shiftImm: begin
						aluSrcA  = 1'b1;
						aluSrcB  = 2'd3;
						rsRd     = 2'd1;
						// Only addi sign-extends its immediate
						zeSe     = (instrClass == aluImm);
						aluOpOut = (instrClass == aluImm) ? aluAdd : aluOp;
					end
					branch: begin
						aluSrcA      = 1'b1;
						pcSource     = 2'd2;
						rsRd         = 2'd2;
						aluOpOut     = aluSub;
						branchEnable = branchMaskT'(1) << branchKind;
					end
					jump: begin
						pcWrite = 1'b1;
					end
					call: begin
						pcWrite  = 1'b1;
						writeReg = 1'b1;
						oldNew   = 1'b1;
						regDest  = 2'd2;
						regData  = 2'd2;
					end
					jumpReg: begin
						pcWrite  = 1'b1;
						aluSrcA  = 1'b1;
						pcSource = 2'd3;
						rsRd     = 2'd2;
					end
					default: begin
					end
				endcase
			end
			writebackStep: begin
				writeReg = 1'b1;
				rsRt     = 1'b1;
				regData  = 2'd1;
			end
			default: begin
			end
		endcase
	end

endmodule

// File: design/multiCycleControl.sv
module multiCycleControl
	import controlPkg::*;
(
	input  logic       Reset,
	input  logic       Clock,
	input  opcodeT     opcode,
	output logic       pcWrite,
	output logic       memRead,
	output logic       irWrite,
	output logic       aluSrcA,
	output logic       zeSe,
	output logic       rsRt,
	output logic       writeReg,
	output logic       oldNew,
	output selT        aluSrcB,
	output selT        pcSource,
	output selT        regDest,
	output selT        regData,
	output selT        rsRd,
	output aluOpT      aluOp,
	output branchMaskT branchEnable
);

	stepT       step;
	instrClassT instrClass;
	aluOpT      decodedAluOp;
	branchKindT branchKind;

	stepSequencer sequencer0 (
		.Reset      (Reset),
		.Clock      (Clock),
		.instrClass (instrClass),
		.step       (step)
	);

	opcodeDecoder decoder0 (
		.Reset      (Reset),
		.Clock      (Clock),
		.step       (step),
		.opcode     (opcode),
		.instrClass (instrClass),
		.aluOp      (decodedAluOp),
		.branchKind (branchKind)
	);

	controlEncoder encoder0 (
		.step         (step),
		.instrClass   (instrClass),
		.aluOp        (decodedAluOp),
		.branchKind   (branchKind),
		.pcWrite      (pcWrite),
		.memRead      (memRead),
		.irWrite      (irWrite),
		.aluSrcA      (aluSrcA),
		.zeSe         (zeSe),
		.rsRt         (rsRt),
		.writeReg     (writeReg),
		.oldNew       (oldNew),
		.aluSrcB      (aluSrcB),
		.pcSource     (pcSource),
		.regDest      (regDest),
		.regData      (regData),
		.rsRd         (rsRd),
		.aluOpOut     (aluOp),
		.branchEnable (branchEnable)
	);

endmodule

// File: sim/clockGen.sv
module clockGen (
	output logic Reset,
	output logic Clock
);

	// Reset is the clock, period 10
	initial begin
		Reset = 1'b0;
		forever #5 Reset = ~Reset;
	end

	// Clock is the reset, held for 10 rising edges
	initial begin
		Clock = 1'b1;
		repeat (10) @(posedge Reset);
		Clock <= 1'b0;
	end

endmodule

// File: sim/control_checker.sv
module controlChecker
	import controlPkg::*;
(
	input logic       Reset,
	input logic       Clock,
	input logic       pcWrite,
	input logic       memRead,
	input logic       irWrite,
	input logic       writeReg,
	input selT        pcSource,
	input branchMaskT branchEnable
);

	int failCount = 0;

	//////////////////////////////////////////////////
	// Control line rules
	//////////////////////////////////////////////////

	branchOneHot: assert property (@(posedge Reset) disable iff (Clock)
		$onehot0(branchEnable))
	else begin
		failCount++;
		$error("more than one branch enable is set");
	end

	// A branch must select the branch target
	branchSelectsTarget: assert property (@(posedge Reset) disable iff (Clock)
		(branchEnable != '0) |-> (pcSource == 2'd2))
	else begin
		failCount++;
		$error("branch enable raised without the branch target select");
	end

	fetchReadsMemory: assert property (@(posedge Reset) disable iff (Clock)
		irWrite |-> (memRead && pcWrite))
	else begin
		failCount++;
		$error("instruction register loaded without memory read and PC update");
	end

	noWriteInFetch: assert property (@(posedge Reset) disable iff (Clock)
		!(writeReg && irWrite))
	else begin
		failCount++;
		$error("register write during instruction fetch");
	end

endmodule

// File: sim/controlTb.sv
module controlTb
	import controlPkg::*;
();

	localparam int instrTotal = 300;
	localparam int cycleLimit = instrTotal * 4 + 10 + 50;

	// Step codes of the reference model
	localparam int idleSt      = 0;
	localparam int fetchSt     = 1;
	localparam int decodeSt    = 2;
	localparam int executeSt   = 3;
	localparam int writebackSt = 4;

	logic        Reset;
	logic        Clock;
	opcodeT      opcode = opNop;
	logic        pcWrite;
	logic        memRead;
	logic        irWrite;
	logic        aluSrcA;
	logic        zeSe;
	logic        rsRt;
	logic        writeReg;
	logic        oldNew;
	selT         aluSrcB;
	selT         pcSource;
	selT         regDest;
	selT         regData;
	selT         rsRd;
	aluOpT       aluOp;
	branchMaskT  branchEnable;

	logic [31:0] lcgState = 32'h2a5cc93f;
	int          modelStep = idleSt;
	opcodeT      modelOp = opNop;
	int          fetchCount = 0;
	int          cycleCount = 0;
	int          checkCount = 0;
	int          errorCount = 0;

	string fieldName [15] = '{"pcWrite", "memRead", "irWrite", "aluSrcA", "zeSe", "rsRt",
		"writeReg", "oldNew", "aluSrcB", "pcSource", "regDest", "regData", "rsRd",
		"aluOp", "branchEnable"};
	int fieldWidth [15] = '{1, 1, 1, 1, 1, 1, 1, 1, 2, 2, 2, 2, 2, 3, 6};

	clockGen clockGen0 (
		.Reset (Reset),
		.Clock (Clock)
	);

	multiCycleControl dut0 (.*);

	bind multiCycleControl controlChecker checker0 (
		.Reset        (Reset),
		.Clock        (Clock),
		.pcWrite      (pcWrite),
		.memRead      (memRead),
		.irWrite      (irWrite),
		.writeReg     (writeReg),
		.pcSource     (pcSource),
		.branchEnable (branchEnable)
	);

	//////////////////////////////////////////////////
	// Stimulus helpers
	//////////////////////////////////////////////////

	function automatic logic [31:0] lcgNext(input logic [31:0] state);
		return state * 32'd1664525 + 32'd1013904223;
	endfunction

	function automatic opcodeT pickOpcode(input logic [31:0] rnd);
		// Roughly one in sixteen lands above the defined range
		if (rnd[31:28] == 4'd0) begin
			return opcodeT'(23 + rnd[23:16] % 9);
		end
		return opcodeT'(rnd[23:16] % 23);
	endfunction

	//////////////////////////////////////////////////
	// Reference model
	//////////////////////////////////////////////////

	function automatic aluOpT aluCodeFor(input opcodeT op);
		case (op)
			opSub:   return aluSub;
			opAnd:   return aluAnd;
			opOr:    return aluOr;
			opNot:   return aluNot;
			opComp:  return aluComp;
			opSll:   return aluSll;
			opSrl:   return aluSrl;
			default: return aluAdd;
		endcase
	endfunction

	function automatic int branchBit(input opcodeT op);
		case (op)
			opBne:   return 1;
			opBlt:   return 2;
			opBgt:   return 3;
			opBlet:  return 4;
			opBget:  return 5;
			default: return 0;
		endcase
	endfunction

	function automatic int stepAfterExecute(input opcodeT op);
		case (op)
			opAdd, opSub, opAnd, opOr, opNot, opComp, opAddi, opSll, opSrl: return writebackSt;
			opBeq, opBne, opBlt, opBgt, opBlet, opBget, opJump, opCall, opJr: return idleSt;
			default: return fetchSt;
		endcase
	endfunction

	// Expected outputs, packed in the order of fieldName
	function automatic logic [26:0] expectedControls(input int st, input opcodeT op);
		logic       pcW, memR, irW, srcA, ze, rt, wr, on;
		logic [1:0] srcB, pcSrc, dest, data, rd;
		logic [2:0] alu;
		logic [5:0] br;
		{pcW, memR, irW, srcA, ze, rt, wr, on} = '0;
		{srcB, pcSrc, dest, data, rd} = '0;
		alu = aluAdd;
		br = '0;
		if (st == fetchSt) begin
			{pcW, memR, irW} = 3'b111;
			srcB = 2'd1;
			pcSrc = 2'd1;
		end else if (st == decodeSt) begin
			srcB = 2'd2;
			pcSrc = 2'd1;
			ze = 1'b1;
		end else if (st == writebackSt) begin
			wr = 1'b1;
			rt = 1'b1;
			data = 2'd1;
		end else if (st == executeSt) begin
			case (op)
				opAdd, opSub, opAnd, opOr, opNot, opComp: begin
					srcA = 1'b1;
					pcSrc = 2'd1;
					rt = 1'b1;
					alu = aluCodeFor(op);
				end
				opAddi, opSll, opSrl: begin
					srcA = 1'b1;
					srcB = 2'd3;
					rd = 2'd1;
					ze = (op == opAddi);
					alu = aluCodeFor(op);
				end
				opBeq, opBne, opBlt, opBgt, opBlet, opBget: begin
					srcA = 1'b1;
					pcSrc = 2'd2;
					rd = 2'd2;
					alu = aluSub;
					br = 6'd1 << branchBit(op);
				end
				opJump: pcW = 1'b1;
				opCall: begin
					{pcW, wr, on} = 3'b111;
					dest = 2'd2;
					data = 2'd2;
				end
				opJr: begin
					{pcW, srcA} = 2'b11;
					pcSrc = 2'd3;
					rd = 2'd2;
				end
				default: begin
				end
			endcase
		end
		return {pcW, memR, irW, srcA, ze, rt, wr, on, srcB, pcSrc, dest, data, rd, alu, br};
	endfunction

	task automatic checkField(input string name, input logic [31:0] expected,
		input logic [31:0] actual);
		checkCount++;
		assert (actual === expected) else begin
			errorCount++;
			$display("[FAIL] %s expected %0h got %0h in cycle %0d",
				name, expected, actual, cycleCount);
		end
	endtask

	//////////////////////////////////////////////////
	// Processes
	//////////////////////////////////////////////////

	always @(posedge Reset) begin
		lcgState = lcgNext(lcgState);
		opcode <= pickOpcode(lcgState);
	end

	// Step and decode latch of the reference
	always @(posedge Reset or posedge Clock) begin
		if (Clock) begin
			modelStep <= idleSt;
		end else begin
			case (modelStep)
				fetchSt: modelStep <= decodeSt;
				decodeSt: begin
					modelOp <= opcode;
					modelStep <= executeSt;
				end
				executeSt: modelStep <= stepAfterExecute(modelOp);
				writebackSt: modelStep <= fetchSt;
				default: modelStep <= fetchSt;
			endcase
		end
	end

	// Compare on the falling edge, away from the updates
	initial begin
		logic [26:0] expected;
		logic [26:0] actual;
		int          pos;
		int          mask;
		@(posedge Reset);
		forever begin
			@(negedge Reset);
			expected = expectedControls(modelStep, modelOp);
			actual = {pcWrite, memRead, irWrite, aluSrcA, zeSe, rsRt, writeReg, oldNew,
				aluSrcB, pcSource, regDest, regData, rsRd, aluOp, branchEnable};
			pos = 27;
			for (int i = 0; i < 15; i++) begin
				pos = pos - fieldWidth[i];
				mask = (1 << fieldWidth[i]) - 1;
				checkField(fieldName[i], 32'(expected >> pos) & mask,
					32'(actual >> pos) & mask);
			end
			// Progress follows the fetches the DUT makes
			if (irWrite === 1'b1) begin
				fetchCount++;
			end
		end
	end

	initial begin
		int assertFails;
		bit timedOut;
		while (fetchCount <= instrTotal && cycleCount < cycleLimit) begin
			@(posedge Reset);
			cycleCount++;
		end
		timedOut = (fetchCount <= instrTotal);
		assertFails = dut0.checker0.failCount;
		if (timedOut) begin
			$display("Timeout: only %0d instructions fetched in %0d cycles",
				fetchCount, cycleCount);
		end
		$display("Checks %0d, value errors %0d, assertion failures %0d",
			checkCount, errorCount, assertFails);
		if (!timedOut && errorCount == 0 && assertFails == 0) begin
			$display("NO ERRORS");
		end else begin
			$display("ERRORS FOUND");
		end
		$finish;
	end

endmodule

// File: flist.f
design/controlPkg.sv
design/stepSequencer.sv
design/opcodeDecoder.sv
design/controlEncoder.sv
design/multiCycleControl.sv
sim/clockGen.sv
sim/control_checker.sv
sim/controlTb.sv

// File: Makefile
# Verilator build and run for the multicycle control unit

VERILATOR  ?= verilator
TOP        ?= controlTb
FLIST      ?= flist.f
BUILD_DIR  ?= obj_dir
LOG        ?= sim.log
LINT_FLAGS ?= --lint-only --timing --assert
SIM_FLAGS  ?= --binary --timing --assert
RUN_ARGS   ?= +verilator+error+limit+1000

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) $(LINT_FLAGS) -f $(FLIST) --top-module $(TOP)

sim:
	$(VERILATOR) $(SIM_FLAGS) -f $(FLIST) --top-module $(TOP) -Mdir $(BUILD_DIR)
	./$(BUILD_DIR)/V$(TOP) $(RUN_ARGS) | tee $(LOG)
	@grep -qx "NO ERRORS" $(LOG) && echo "Simulation passed" || \
		(echo "Simulation failed, see $(LOG)"; exit 1)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
